//--- Bender.yml
package:
  name: comb_nonspec_allocator

sources:
  - verilog/allocator_pkg.sv
  - verilog/rr_arbiter.sv
  - verilog/ovc_candidate_arbiter.sv
  - verilog/nonspec_sw_alloc.sv
  - verilog/ovc_grant_route.sv
  - verilog/comb_nonspec_allocator.sv
  - target: test
    files:
      - verification/allocator_assert.sv
      - verification/tb_comb_nonspec_allocator.sv

//--- verification/allocator_assert.sv
`timescale 1ns/1ps
`default_nettype none

module allocator_assert (
    input logic                                clk,
    input logic                                rst_n,
    input logic [allocator_pkg::num_ivcs-1:0]    ivc_req,
    input logic [allocator_pkg::ovc_req_w-1:0]   masked_ovc_request,
    input logic [allocator_pkg::num_ivcs-1:0]    ivc_num_getting_sw_grant,
    input logic [allocator_pkg::grant_dst_w-1:0] granted_dest_port,
    input logic [allocator_pkg::num_ports-1:0]   any_ivc_sw_request_granted,
    input logic [allocator_pkg::num_ports-1:0]   any_ovc_granted_in_outport,
    input logic [allocator_pkg::ovc_req_w-1:0]   granted_ovc_num,
    input logic [allocator_pkg::num_ivcs-1:0]    ivc_num_getting_ovc_grant,
    input logic [allocator_pkg::num_ivcs-1:0]    ovc_allocated
);

    import allocator_pkg::*;

    int fail_count;  // failed assertion count

    initial fail_count = 0;

    genvar gp;
    genvar gv;

    generate
        for (gp = 0; gp < num_ports; gp++) begin : g_port
            a_sw_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot0(ivc_num_getting_sw_grant[gp*num_vcs +: num_vcs]))
                else begin
                    $error("more than one VC of a port won the switch");
                    fail_count++;
                end
            a_dst_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot0(granted_dest_port[gp*num_dst +: num_dst]))
                else begin
                    $error("granted destination not one-hot");
                    fail_count++;
                end
            a_alloc_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot0(ovc_allocated[gp*num_vcs +: num_vcs]))
                else begin
                    $error("more than one OVC allocated at an output port");
                    fail_count++;
                end
        end
        for (gv = 0; gv < num_ivcs; gv++) begin : g_ivc
            a_ovc_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot0(granted_ovc_num[gv*num_vcs +: num_vcs]))
                else begin
                    $error("granted OVC number not one-hot");
                    fail_count++;
                end
            // a new OVC must be one the IVC asked for
            a_ovc_in_mask: assert property (@(posedge clk) disable iff (!rst_n)
                ivc_num_getting_ovc_grant[gv] |->
                ((granted_ovc_num[gv*num_vcs +: num_vcs]
                  & ~masked_ovc_request[gv*num_vcs +: num_vcs]) == '0))
                else begin
                    $error("granted OVC outside the free-OVC request");
                    fail_count++;
                end
        end
    endgenerate

    a_ovc_needs_sw: assert property (@(posedge clk) disable iff (!rst_n)
        (ivc_num_getting_ovc_grant & ~ivc_num_getting_sw_grant) == '0)
        else begin
            $error("OVC grant without switch grant");
            fail_count++;
        end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (ivc_req == '0) |-> (ivc_num_getting_sw_grant == '0 && granted_dest_port == '0
            && any_ivc_sw_request_granted == '0 && any_ovc_granted_in_outport == '0
            && granted_ovc_num == '0 && ivc_num_getting_ovc_grant == '0
            && ovc_allocated == '0))
        else begin
            $error("output active with no IVC request");
            fail_count++;
        end

endmodule

bind comb_nonspec_allocator allocator_assert u_assert (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .ivc_req                   (ivc_req),
    .masked_ovc_request        (masked_ovc_request),
    .ivc_num_getting_sw_grant  (ivc_num_getting_sw_grant),
    .granted_dest_port         (granted_dest_port),
    .any_ivc_sw_request_granted(any_ivc_sw_request_granted),
    .any_ovc_granted_in_outport(any_ovc_granted_in_outport),
    .granted_ovc_num           (granted_ovc_num),
    .ivc_num_getting_ovc_grant (ivc_num_getting_ovc_grant),
    .ovc_allocated             (ovc_allocated)
);

`default_nettype wire

//--- verification/tb_comb_nonspec_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_comb_nonspec_allocator;

    import allocator_pkg::*;

    localparam int half_period   = 50;
    localparam int grant_timeout = 16;  // cycles

    logic                   clk;
    logic                   rst_n;
    logic [num_ivcs-1:0]    ivc_req;
    logic [num_ivcs-1:0]    ovc_is_assigned;
    logic [num_ivcs-1:0]    assigned_ovc_not_full;
    logic [ovc_req_w-1:0]   masked_ovc_request;
    logic [dst_w-1:0]       dest_port;
    logic [num_ivcs-1:0]    ivc_num_getting_sw_grant;
    logic [grant_dst_w-1:0] granted_dest_port;
    logic [num_ports-1:0]   any_ivc_sw_request_granted;
    logic [num_ports-1:0]   any_ovc_granted_in_outport;
    logic [ovc_req_w-1:0]   granted_ovc_num;
    logic [num_ivcs-1:0]    ivc_num_getting_ovc_grant;
    logic [num_ivcs-1:0]    ovc_allocated;

    int num_checks;
    int num_errors;

    comb_nonspec_allocator dut0 (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .ivc_req                   (ivc_req),
        .ovc_is_assigned           (ovc_is_assigned),
        .assigned_ovc_not_full     (assigned_ovc_not_full),
        .masked_ovc_request        (masked_ovc_request),
        .dest_port                 (dest_port),
        .ivc_num_getting_sw_grant  (ivc_num_getting_sw_grant),
        .granted_dest_port         (granted_dest_port),
        .any_ivc_sw_request_granted(any_ivc_sw_request_granted),
        .any_ovc_granted_in_outport(any_ovc_granted_in_outport),
        .granted_ovc_num           (granted_ovc_num),
        .ivc_num_getting_ovc_grant (ivc_num_getting_ovc_grant),
        .ovc_allocated             (ovc_allocated)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // local destination bit that port own uses for output port other
    function automatic int dst_bit(input int own, input int other);
        return (other < own) ? other : other - 1;
    endfunction

    // output port behind local bit k of port own
    function automatic int port_of_bit(input int own, input int k);
        return (k < own) ? k : k + 1;
    endfunction

    // reference round robin, first request at or after ptr
    function automatic int rr_pick(input logic [7:0] req, input int ptr, input int w);
        int idx;
        for (int k = 0; k < w; k++) begin
            idx = (ptr + k) % w;
            if (req[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("Error at time %0t: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic clear_inputs();
        ivc_req               = '0;
        ovc_is_assigned       = '0;
        assigned_ovc_not_full = '0;
        masked_ovc_request    = '0;
        dest_port             = '0;
    endtask

    task automatic to_drive_point();
        @(posedge clk);
        #1;
    endtask

    // just before the next rising edge
    task automatic to_sample_point();
        #(2*half_period - 3);
    endtask

    // leaves the run at a drive point
    task automatic apply_reset();
        clear_inputs();
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic request_assigned(input int n, input int k);
        ivc_req[n]                        = 1'b1;
        ovc_is_assigned[n]                = 1'b1;
        assigned_ovc_not_full[n]          = 1'b1;
        dest_port[n*num_dst +: num_dst]   = num_dst'(1) << k;
    endtask

    task automatic wait_sw_grant(input int n, output int cycles);
        cycles = 0;
        to_sample_point();
        while (!ivc_num_getting_sw_grant[n] && cycles < grant_timeout) begin
            to_drive_point();
            to_sample_point();
            cycles++;
        end
        if (!ivc_num_getting_sw_grant[n]) begin
            $display("Timeout while waiting for a switch grant to input VC %0d", n);
            $display("TEST FAILED");
            $finish;
        end
    endtask

    task automatic test_idle();
        apply_reset();
        to_sample_point();
        check_value(ivc_num_getting_sw_grant, '0, "idle switch grant");
        check_value(granted_dest_port, '0, "idle granted destination");
        check_value(any_ivc_sw_request_granted, '0, "idle input port grant");
        check_value(any_ovc_granted_in_outport, '0, "idle output port grant");
        check_value(granted_ovc_num, '0, "idle OVC number");
        check_value(ivc_num_getting_ovc_grant, '0, "idle OVC grant");
        check_value(ovc_allocated, '0, "idle OVC allocated");
    endtask

    task automatic test_assigned();
        int p;
        int k;
        int n;
        int cycles;
        apply_reset();
        p = $urandom % num_ports;
        k = $urandom % num_dst;
        n = p*num_vcs + $urandom % num_vcs;
        request_assigned(n, k);
        wait_sw_grant(n, cycles);
        check_value(cycles, 0, "assigned grant latency");
        check_value(ivc_num_getting_sw_grant, 128'(1) << n, "assigned switch grant");
        check_value(granted_dest_port, 128'(1) << (p*num_dst + k), "assigned destination");
        check_value(any_ivc_sw_request_granted, 128'(1) << p, "assigned input port");
        check_value(any_ovc_granted_in_outport, 128'(1) << port_of_bit(p, k),
                    "assigned output port");
        check_value(ivc_num_getting_ovc_grant, '0, "assigned gets no new OVC");
        check_value(ovc_allocated, '0, "assigned allocates no OVC");
    endtask

    task automatic test_full();
        int n;
        apply_reset();
        n = $urandom % num_ivcs;
        request_assigned(n, $urandom % num_dst);
        assigned_ovc_not_full[n] = 1'b0;  // owned OVC has no room
        to_sample_point();
        check_value(ivc_num_getting_sw_grant, '0, "full switch grant");
        check_value(granted_dest_port, '0, "full granted destination");
        check_value(ivc_num_getting_ovc_grant, '0, "full OVC grant");
        check_value(ovc_allocated, '0, "full OVC allocated");
    endtask

    task automatic test_new_ovc();
        int p;
        int k;
        int n;
        int c;
        int cycles;
        apply_reset();
        p = $urandom % num_ports;
        k = $urandom % num_dst;
        n = p*num_vcs + $urandom % num_vcs;
        c = $urandom % num_vcs;
        ivc_req[n]                        = 1'b1;
        dest_port[n*num_dst +: num_dst]   = num_dst'(1) << k;
        masked_ovc_request[n*num_vcs + c] = 1'b1;
        wait_sw_grant(n, cycles);
        check_value(cycles, 0, "new OVC grant latency");
        check_value(granted_ovc_num[n*num_vcs +: num_vcs], 128'(1) << c, "new OVC number");
        check_value(ivc_num_getting_ovc_grant, 128'(1) << n, "new OVC grant");
        check_value(ovc_allocated, 128'(1) << (port_of_bit(p, k)*num_vcs + c),
                    "new OVC allocated");
    endtask

    task automatic test_output_contention();
        int o;
        int ka;
        int kb;
        int pa;
        int pb;
        int na;
        int nb;
        int ptr;
        int win;
        logic [7:0] req;
        apply_reset();
        o  = $urandom % num_ports;
        ka = $urandom % num_dst;
        kb = (ka + 1 + $urandom % (num_dst - 1)) % num_dst;
        pa = port_of_bit(o, ka);
        pb = port_of_bit(o, kb);
        na = pa*num_vcs + $urandom % num_vcs;
        nb = pb*num_vcs + $urandom % num_vcs;
        request_assigned(na, dst_bit(pa, o));
        request_assigned(nb, dst_bit(pb, o));
        req     = '0;
        req[ka] = 1'b1;
        req[kb] = 1'b1;
        ptr     = 0;
        for (int c = 0; c < 4; c++) begin
            if (c > 0) begin
                to_drive_point();  // requests held
            end
            to_sample_point();
            win = rr_pick(req, ptr, num_dst);
            check_value(ivc_num_getting_sw_grant, 128'(1) << ((win == ka) ? na : nb),
                        "output contention winner");
            ptr = (win + 1) % num_dst;
        end
    endtask

    task automatic test_input_contention();
        int p;
        int va;
        int vb;
        int ka;
        int kb;
        int ptr;
        int win;
        logic [7:0] req;
        apply_reset();
        p  = $urandom % num_ports;
        va = $urandom % num_vcs;
        vb = (va + 1 + $urandom % (num_vcs - 1)) % num_vcs;
        ka = $urandom % num_dst;
        kb = (ka + 1 + $urandom % (num_dst - 1)) % num_dst;
        request_assigned(p*num_vcs + va, ka);
        request_assigned(p*num_vcs + vb, kb);
        req     = '0;
        req[va] = 1'b1;
        req[vb] = 1'b1;
        ptr     = 0;
        for (int c = 0; c < 4; c++) begin
            if (c > 0) begin
                to_drive_point();
            end
            to_sample_point();
            win = rr_pick(req, ptr, num_vcs);
            check_value(ivc_num_getting_sw_grant, 128'(1) << (p*num_vcs + win),
                        "input contention winner");
            check_value(granted_dest_port, 128'(1) << (p*num_dst + ((win == va) ? ka : kb)),
                        "input contention destination");
            ptr = (win + 1) % num_vcs;
        end
    endtask

    initial begin
        num_checks = 0;
        num_errors = 0;
        rst_n      = 1'b0;
        clear_inputs();
        void'($urandom(82));
        test_idle();
        test_assigned();
        test_full();
        test_new_ovc();
        test_output_contention();
        test_input_contention();
        $display("checks run %0d, errors %0d, assertion failures %0d",
                 num_checks, num_errors, dut0.u_assert.fail_count);
        if (num_errors == 0 && dut0.u_assert.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/allocator_pkg.sv
`default_nettype none

package allocator_pkg;

    // router dimensions
    localparam int num_ports = 5;
    localparam int num_vcs   = 4;

    // no self loop so a flit never returns to its own port
    localparam int num_dst = num_ports - 1;

    // flattened input VC count, ivc index = port * num_vcs + vc
    localparam int num_ivcs = num_ports * num_vcs;

    // one free-OVC request bit per OVC, per input VC
    localparam int ovc_req_w = num_ivcs * num_vcs;

    // one-hot local destination per input VC
    localparam int dst_w = num_ivcs * num_dst;

    // granted destination per input port
    localparam int grant_dst_w = num_ports * num_dst;

    // local destination bit k of input port in_port to the global output port
    function automatic int dst_to_port(
        input int in_port,
        input int k
    );
        if (k < in_port) begin
            return k;
        end
        return k + 1;
    endfunction

    // global output port to the local destination bit of input port in_port
    // out_port must differ from in_port
    function automatic int port_to_dst(
        input int in_port,
        input int out_port
    );
        if (out_port < in_port) begin
            return out_port;
        end
        return out_port - 1;
    endfunction

endpackage

`default_nettype wire

//--- verilog/comb_nonspec_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module comb_nonspec_allocator (
    input  logic                                clk,
    input  logic                                rst_n,

    // per input VC status
    input  logic [allocator_pkg::num_ivcs-1:0]    ivc_req,
    input  logic [allocator_pkg::num_ivcs-1:0]    ovc_is_assigned,
    input  logic [allocator_pkg::num_ivcs-1:0]    assigned_ovc_not_full,
    input  logic [allocator_pkg::ovc_req_w-1:0]   masked_ovc_request,
    input  logic [allocator_pkg::dst_w-1:0]       dest_port,

    // switch allocation results
    output logic [allocator_pkg::num_ivcs-1:0]    ivc_num_getting_sw_grant,
    output logic [allocator_pkg::grant_dst_w-1:0] granted_dest_port,
    output logic [allocator_pkg::num_ports-1:0]   any_ivc_sw_request_granted,
    output logic [allocator_pkg::num_ports-1:0]   any_ovc_granted_in_outport,

    // VC allocation results
    output logic [allocator_pkg::ovc_req_w-1:0]   granted_ovc_num,
    output logic [allocator_pkg::num_ivcs-1:0]    ivc_num_getting_ovc_grant,
    output logic [allocator_pkg::num_ivcs-1:0]    ovc_allocated
);

    import allocator_pkg::*;

    logic [num_ivcs-1:0]  ivc_request_masked;  // IVCs allowed into switch allocation
    logic [ovc_req_w-1:0] candidate_ovc;       // nominated free OVC per IVC
    logic [num_ivcs-1:0]  first_grant;

    genvar gn;

    generate
        for (gn = 0; gn < num_ivcs; gn++) begin : g_ivc
            ovc_candidate_arbiter u_cand_arb (
                .clk                  (clk),
                .rst_n                (rst_n),
                .ivc_req              (ivc_req[gn]),
                .ovc_is_assigned      (ovc_is_assigned[gn]),
                .assigned_ovc_not_full(assigned_ovc_not_full[gn]),
                .ovc_request          (masked_ovc_request[gn*num_vcs +: num_vcs]),
                .sw_request           (ivc_request_masked[gn]),
                .candidate_ovc        (candidate_ovc[gn*num_vcs +: num_vcs])
            );
        end
    endgenerate

    nonspec_sw_alloc u_sw_alloc (
        .clk               (clk),
        .rst_n             (rst_n),
        .ivc_request_masked(ivc_request_masked),
        .dest_port         (dest_port),
        .ivc_granted       (ivc_num_getting_sw_grant),
        .first_grant       (first_grant),
        .granted_dest_port (granted_dest_port),
        .any_ivc_granted   (any_ivc_sw_request_granted),
        .any_ovc_granted   (any_ovc_granted_in_outport)
    );

    // OVC grant follows the switch decision in the same cycle
    ovc_grant_route u_grant_route (
        .candidate_ovc            (candidate_ovc),
        .ovc_is_assigned          (ovc_is_assigned),
        .first_grant              (first_grant),
        .granted_dest_port        (granted_dest_port),
        .any_ivc_granted          (any_ivc_sw_request_granted),
        .granted_ovc_num          (granted_ovc_num),
        .ivc_num_getting_ovc_grant(ivc_num_getting_ovc_grant),
        .ovc_allocated            (ovc_allocated)
    );

endmodule

`default_nettype wire

//--- verilog/nonspec_sw_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module nonspec_sw_alloc (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [allocator_pkg::num_ivcs-1:0]    ivc_request_masked,
    input  logic [allocator_pkg::dst_w-1:0]       dest_port,
    output logic [allocator_pkg::num_ivcs-1:0]    ivc_granted,
    output logic [allocator_pkg::num_ivcs-1:0]    first_grant,
    output logic [allocator_pkg::grant_dst_w-1:0] granted_dest_port,
    output logic [allocator_pkg::num_ports-1:0]   any_ivc_granted,  // per input port
    output logic [allocator_pkg::num_ports-1:0]   any_ovc_granted   // per output port
);

    import allocator_pkg::*;

    logic [num_dst-1:0] sel_dst   [num_ports];  // destination of each first-level winner
    logic [num_dst-1:0] out_req   [num_ports];  // requests seen by each output arbiter
    logic [num_dst-1:0] out_grant [num_ports];

    genvar gi;

    generate
        for (gi = 0; gi < num_ports; gi++) begin : g_in_arb
            // pointer only moves when the port really got through
            rr_arbiter #(
                .width(num_vcs)
            ) u_in_arb (
                .clk        (clk),
                .rst_n      (rst_n),
                .request    (ivc_request_masked[gi*num_vcs +: num_vcs]),
                .priority_en(any_ivc_granted[gi]),
                .grant      (first_grant[gi*num_vcs +: num_vcs]),
                .any_grant  ()
            );
        end
    endgenerate

    // one-hot mux of the winner's destination
    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            sel_dst[i] = '0;
            for (int v = 0; v < num_vcs; v++) begin
                if (first_grant[i*num_vcs + v]) begin
                    sel_dst[i] |= dest_port[(i*num_vcs + v)*num_dst +: num_dst];
                end
            end
        end
    end

    // bit k of output o comes from input port dst_to_port(o, k)
    always_comb begin
        int j;
        for (int o = 0; o < num_ports; o++) begin
            for (int k = 0; k < num_dst; k++) begin
                j = dst_to_port(o, k);
                out_req[o][k] = sel_dst[j][port_to_dst(j, o)];
            end
        end
    end

    generate
        for (gi = 0; gi < num_ports; gi++) begin : g_out_arb
            rr_arbiter #(
                .width(num_dst)
            ) u_out_arb (
                .clk        (clk),
                .rst_n      (rst_n),
                .request    (out_req[gi]),
                .priority_en(any_ovc_granted[gi]),
                .grant      (out_grant[gi]),
                .any_grant  (any_ovc_granted[gi])
            );
        end
    endgenerate

    // output grants back into the local encoding of each input port
    always_comb begin
        int o;
        granted_dest_port = '0;
        for (int i = 0; i < num_ports; i++) begin
            for (int k = 0; k < num_dst; k++) begin
                o = dst_to_port(i, k);
                granted_dest_port[i*num_dst + k] = out_grant[o][port_to_dst(o, i)];
            end
            any_ivc_granted[i] = |granted_dest_port[i*num_dst +: num_dst];
            ivc_granted[i*num_vcs +: num_vcs] =
                any_ivc_granted[i] ? first_grant[i*num_vcs +: num_vcs] : '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ovc_candidate_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ovc_candidate_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ivc_req,
    input  logic                        ovc_is_assigned,
    input  logic                        assigned_ovc_not_full,
    input  logic [allocator_pkg::num_vcs-1:0] ovc_request,   // free OVCs this IVC may take
    output logic                        sw_request,
    output logic [allocator_pkg::num_vcs-1:0] candidate_ovc
);

    import allocator_pkg::*;

    logic assigned_ready;  // owned OVC has room
    logic free_ovc_avail;  // at least one free OVC to nominate

    assign assigned_ready = ivc_req & ovc_is_assigned & assigned_ovc_not_full;

    // either path lets the IVC enter switch allocation
    assign sw_request = assigned_ready | free_ovc_avail;

    // rotates every cycle there is something to pick from
    // the candidate only sticks if the IVC wins the switch
    rr_arbiter #(
        .width(num_vcs)
    ) u_ovc_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .request    (ovc_request),
        .priority_en(free_ovc_avail),
        .grant      (candidate_ovc),
        .any_grant  (free_ovc_avail)
    );

endmodule

`default_nettype wire

//--- verilog/ovc_grant_route.sv
`timescale 1ns/1ps
`default_nettype none

module ovc_grant_route (
    input  logic [allocator_pkg::ovc_req_w-1:0]   candidate_ovc,
    input  logic [allocator_pkg::num_ivcs-1:0]    ovc_is_assigned,
    input  logic [allocator_pkg::num_ivcs-1:0]    first_grant,
    input  logic [allocator_pkg::grant_dst_w-1:0] granted_dest_port,
    input  logic [allocator_pkg::num_ports-1:0]   any_ivc_granted,
    output logic [allocator_pkg::ovc_req_w-1:0]   granted_ovc_num,
    output logic [allocator_pkg::num_ivcs-1:0]    ivc_num_getting_ovc_grant,
    output logic [allocator_pkg::num_ivcs-1:0]    ovc_allocated   // output port * num_vcs + ovc
);

    import allocator_pkg::*;

    logic [num_vcs-1:0] win_cand [num_ports];  // candidate of the first-level winner
    logic [num_vcs-1:0] port_ovc [num_ports];  // gated by the switch result
    logic [num_ports-1:0] win_assigned;

    // per input port selection by the first-level grant
    always_comb begin
        logic [num_vcs-1:0] grant_v;
        for (int i = 0; i < num_ports; i++) begin
            grant_v = first_grant[i*num_vcs +: num_vcs];
            win_cand[i] = '0;
            for (int v = 0; v < num_vcs; v++) begin
                if (grant_v[v]) begin
                    win_cand[i] |= candidate_ovc[(i*num_vcs + v)*num_vcs +: num_vcs];
                end
            end
            win_assigned[i] = |(grant_v & ovc_is_assigned[i*num_vcs +: num_vcs]);

            port_ovc[i] = any_ivc_granted[i] ? win_cand[i] : '0;

            // only a winner without an OVC gets a new one
            ivc_num_getting_ovc_grant[i*num_vcs +: num_vcs] =
                (any_ivc_granted[i] && !win_assigned[i]) ? grant_v : '0;

            for (int v = 0; v < num_vcs; v++) begin
                granted_ovc_num[(i*num_vcs + v)*num_vcs +: num_vcs] = port_ovc[i];
            end
        end
    end

    // demux each candidate to its granted output and OR per output port
    always_comb begin
        int d;
        ovc_allocated = '0;
        for (int o = 0; o < num_ports; o++) begin
            for (int j = 0; j < num_ports; j++) begin
                if (j != o) begin
                    d = port_to_dst(j, o);
                    if (granted_dest_port[j*num_dst + d]) begin
                        ovc_allocated[o*num_vcs +: num_vcs] |= port_ovc[j];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter int width = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [width-1:0] request,
    input  logic             priority_en,  // lets the pointer move past the winner
    output logic [width-1:0] grant,
    output logic             any_grant
);

    localparam int ptr_w = (width > 1) ? $clog2(width) : 1;

    logic [ptr_w-1:0] ptr;       // index with highest priority
    logic [ptr_w-1:0] win_idx;   // encoded winner
    logic [ptr_w-1:0] ptr_next;

    // cyclic search starting at the pointer
    always_comb begin
        int   idx;
        logic found;
        grant   = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int k = 0; k < width; k++) begin
            idx = (int'(ptr) + k) % width;
            if (!found && request[idx]) begin
                grant[idx] = 1'b1;
                win_idx    = ptr_w'(idx);
                found      = 1'b1;
            end
        end
    end

    assign any_grant = |request;

    // winner gets lowest priority next time
    assign ptr_next = (int'(win_idx) == width - 1) ? '0 : win_idx + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (priority_en && any_grant) begin
            ptr <= ptr_next;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/allocator_pkg.sv
verilog/rr_arbiter.sv
verilog/ovc_candidate_arbiter.sv
verilog/nonspec_sw_alloc.sv
verilog/ovc_grant_route.sv
verilog/comb_nonspec_allocator.sv
verification/allocator_assert.sv
verification/tb_comb_nonspec_allocator.sv
